//--- ar_channel.sv
`timescale 1ns/1ns
`include "refill_bridge_defs.svh"

module ar_channel (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       i_load,
    input  refill_bridge_pkg::rd_src_t i_src,
    input  refill_bridge_pkg::addr_t   i_ic_addr,
    input  refill_bridge_pkg::addr_t   i_dc_addr,
    input  logic                       i_arready,
    output logic                       o_arvalid,
    output refill_bridge_pkg::addr_t   o_araddr,
    output refill_bridge_pkg::axi_id_t o_arid,
    output logic                       o_busy,
    output logic                       o_done,
    output logic                       o_ic_rdy,
    output logic                       o_dc_rdy
);
    import refill_bridge_pkg::*;

    logic    arvalid_q;
    rd_src_t src_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arvalid_q <= 1'b0;
        end else if (i_load) begin
            arvalid_q <= 1'b1;
        end else if (o_done) begin
            arvalid_q <= 1'b0;
        end
    end

    // address and id stay put until arready
    always_ff @(posedge aclk) begin
        if (i_load) begin
            src_q <= i_src;
            if (i_src == ICACHE) begin
                o_araddr <= i_ic_addr;
                o_arid   <= axi_id_t'(`ID_ICACHE);
            end else begin
                o_araddr <= i_dc_addr;
                o_arid   <= axi_id_t'(`ID_DCACHE);
            end
        end
    end

    assign o_arvalid = arvalid_q;
    assign o_busy    = arvalid_q;
    assign o_done    = arvalid_q && i_arready;
    assign o_ic_rdy  = o_done && (src_q == ICACHE);
    assign o_dc_rdy  = o_done && (src_q == DCACHE);

endmodule

//--- r_router.sv
`timescale 1ns/1ns
`include "refill_bridge_defs.svh"

module r_router (
    input  logic                       i_rvalid,
    input  refill_bridge_pkg::axi_id_t i_rid,
    input  refill_bridge_pkg::word_t   i_rdata,
    input  logic                       i_rlast,
    input  logic                       i_ic_data_ready,
    input  logic                       i_dc_data_ready,
    output logic                       o_rready,
    output logic                       o_ic_ret_valid,
    output logic                       o_ic_ret_last,
    output refill_bridge_pkg::word_t   o_ic_rdata,
    output logic                       o_dc_ret_valid,
    output logic                       o_dc_ret_last,
    output refill_bridge_pkg::word_t   o_dc_rdata,
    output logic                       o_rlast_beat,
    output refill_bridge_pkg::rd_src_t o_rlast_src
);
    import refill_bridge_pkg::*;

    rd_src_t rd_src;
    logic    beat_take;

    // any id other than the data side's goes to the instruction side
    assign rd_src = (i_rid == axi_id_t'(`ID_DCACHE)) ? DCACHE : ICACHE;

    assign o_rready  = (rd_src == DCACHE) ? i_dc_data_ready : i_ic_data_ready;
    assign beat_take = i_rvalid && o_rready;

    // ret_valid marks a beat actually taken on R
    assign o_ic_ret_valid = beat_take && (rd_src == ICACHE);
    assign o_ic_ret_last  = o_ic_ret_valid && i_rlast;
    assign o_ic_rdata     = i_rdata;

    assign o_dc_ret_valid = beat_take && (rd_src == DCACHE);
    assign o_dc_ret_last  = o_dc_ret_valid && i_rlast;
    assign o_dc_rdata     = i_rdata;

    assign o_rlast_beat = beat_take && i_rlast;
    assign o_rlast_src  = rd_src;

endmodule

//--- refill_bridge_asserts.sv
`timescale 1ns/1ns
`include "refill_bridge_defs.svh"

module refill_bridge_asserts (
    input logic                       aclk,
    input logic                       aresetn,
    input logic                       o_arvalid,
    input logic                       i_arready,
    input refill_bridge_pkg::axi_id_t o_arid,
    input refill_bridge_pkg::addr_t   o_araddr,
    input logic                       o_awvalid,
    input logic                       i_awready,
    input refill_bridge_pkg::axi_id_t o_awid,
    input refill_bridge_pkg::addr_t   o_awaddr,
    input logic                       o_wvalid,
    input logic                       o_bready,
    input refill_bridge_pkg::axi_id_t i_rid,
    input logic                       o_ic_rdy,
    input logic                       o_dc_rdy,
    input logic                       o_dc_b_valid,
    input logic                       o_ic_ret_valid,
    input logic                       o_dc_ret_valid
);

    int fail_cnt = 0;

    // everything idle one cycle after a reset cycle
    reset_idle: assert property (@(posedge aclk) !aresetn |=>
        !o_arvalid && !o_awvalid && !o_wvalid && !o_bready &&
        !o_ic_rdy && !o_dc_rdy && !o_dc_b_valid)
    else begin
        fail_cnt++;
        $error("outputs not idle after reset");
    end

    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr) && $stable(o_arid))
    else begin
        fail_cnt++;
        $error("AR channel changed before arready");
    end

    aw_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr) && $stable(o_awid))
    else begin
        fail_cnt++;
        $error("AW channel changed before awready");
    end

    // a returned beat reaches only the side its rid names
    ret_by_rid: assert property (@(posedge aclk) disable iff (!aresetn)
        (!o_ic_ret_valid || i_rid == `ID_ICACHE) &&
        (!o_dc_ret_valid || i_rid == `ID_DCACHE))
    else begin
        fail_cnt++;
        $error("read beat routed to a side its rid does not name");
    end

    // bready closes right after the B handshake
    b_close: assert property (@(posedge aclk) disable iff (!aresetn)
        o_dc_b_valid |=> !o_bready)
    else begin
        fail_cnt++;
        $error("bready still high after the write response");
    end

endmodule

//--- refill_bridge_defs.svh
`ifndef REFILL_BRIDGE_DEFS_SVH
`define REFILL_BRIDGE_DEFS_SVH

// AXI port widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4
`define ID_W 4

// one cache line, incrementing 32-bit beats
`define BURST_BEATS 16
`define BEAT_CNT_W 4

// transaction IDs per source
`define ID_ICACHE 0
`define ID_DCACHE 1

`endif

//--- refill_bridge_pkg.sv
`include "refill_bridge_defs.svh"

package refill_bridge_pkg;

    typedef logic [`ADDR_W-1:0]     addr_t;
    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`STRB_W-1:0]     strb_t;
    typedef logic [`ID_W-1:0]       axi_id_t;
    typedef logic [`BEAT_CNT_W-1:0] beat_cnt_t;

    typedef enum logic {
        ICACHE,
        DCACHE
    } rd_src_t;

    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } wr_state_t;

endpackage

//--- refill_bridge_tb.sv
`timescale 1ns/1ns
`include "refill_bridge_defs.svh"

module refill_bridge_tb;
    import refill_bridge_pkg::*;

    localparam int TIMEOUT = 4000;

    logic    aclk = 1'b0;
    logic    aresetn;
    logic    ic_req, ic_rdy, ic_ret_valid, ic_ret_last, ic_data_ready;
    addr_t   ic_addr;
    word_t   ic_rdata;
    logic    dc_req, dc_rdy, dc_ret_valid, dc_ret_last, dc_data_ready;
    addr_t   dc_addr;
    word_t   dc_rdata;
    logic    dc_w_req, dc_w_rdy, dc_w_data_req, dc_w_data_ready, dc_b_valid;
    addr_t   dc_w_addr;
    strb_t   dc_w_strb;
    word_t   dc_w_data;
    axi_id_t arid, rid, awid;
    addr_t   araddr, awaddr;
    word_t   rdata, wdata;
    strb_t   wstrb, wstrb_q, exp_wstrb;
    logic    arvalid, arready, rlast, rvalid, rready;
    logic    awvalid, awready, wlast, wvalid, wready, bvalid, bready, b_hs;

    // memory model state and reference image
    word_t   mem [0:1023];
    word_t   ref_mem [0:1023];
    addr_t   rd_addr_q[$];
    axi_id_t rd_id_q[$];
    axi_id_t ar_ids[$];
    word_t   w_q[$];
    addr_t   aw_addr, exp_waddr, ic_base, dc_base;
    logic    aw_seen;
    logic    [1:0] outstanding;
    int      errors, cycles, b_count, dc_b_cnt, ic_idx, dc_idx, ic_lines, dc_lines;
    integer  seed = 32'h1a6c_52b3;

    refill_bridge_top DUT (
        .aclk(aclk), .aresetn(aresetn),
        .i_ic_req(ic_req), .i_ic_addr(ic_addr), .o_ic_rdy(ic_rdy),
        .o_ic_ret_valid(ic_ret_valid), .o_ic_ret_last(ic_ret_last),
        .o_ic_rdata(ic_rdata), .i_ic_data_ready(ic_data_ready),
        .i_dc_req(dc_req), .i_dc_addr(dc_addr), .o_dc_rdy(dc_rdy),
        .o_dc_ret_valid(dc_ret_valid), .o_dc_ret_last(dc_ret_last),
        .o_dc_rdata(dc_rdata), .i_dc_data_ready(dc_data_ready),
        .i_dc_w_req(dc_w_req), .i_dc_w_addr(dc_w_addr), .i_dc_w_strb(dc_w_strb),
        .o_dc_w_rdy(dc_w_rdy), .i_dc_w_data_req(dc_w_data_req), .i_dc_w_data(dc_w_data),
        .o_dc_w_data_ready(dc_w_data_ready), .o_dc_b_valid(dc_b_valid),
        .o_arid(arid), .o_araddr(araddr), .o_arvalid(arvalid), .i_arready(arready),
        .i_rid(rid), .i_rdata(rdata), .i_rlast(rlast), .i_rvalid(rvalid), .o_rready(rready),
        .o_awid(awid), .o_awaddr(awaddr), .o_awvalid(awvalid), .i_awready(awready),
        .o_wdata(wdata), .o_wstrb(wstrb), .o_wlast(wlast), .o_wvalid(wvalid),
        .i_wready(wready), .i_bvalid(bvalid), .o_bready(bready)
    );

    bind refill_bridge_top refill_bridge_asserts u_asserts (.*);

    function automatic word_t fill_word(input int idx);
        word_t a;
        a = idx * 4;
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    // byte lanes with a set strobe take the new word
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t strb);
        word_t m;
        m = old_w;
        for (int b = 0; b < `STRB_W; b++) begin
            if (strb[b]) begin
                m[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return m;
    endfunction

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        errors++;
        $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
    endtask

    always #10 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // random ready levels on AXI and both cache sides
    always @(posedge aclk) begin
        #2;
        arready = ($random(seed) & 3) != 0;
        awready = ($random(seed) & 3) != 0;
        wready = ($random(seed) & 3) != 0;
        ic_data_ready = ($random(seed) & 3) != 0;
        dc_data_ready = ($random(seed) & 3) != 0;
    end

    // AR, W and B side of the memory model
    always @(posedge aclk) begin
        b_hs = aresetn && bvalid && bready;
        if (aresetn && arvalid && arready) begin
            assert (!outstanding[arid[0]]) else begin
                errors++;
                $display("second AR for id %0d issued before its rlast", arid);
            end
            outstanding[arid[0]] = 1'b1;
            rd_addr_q.push_back(araddr);
            rd_id_q.push_back(arid);
            ar_ids.push_back(arid);
        end
        if (aresetn && rvalid && rready && rlast) begin
            outstanding[rid[0]] = 1'b0;
        end
        if (aresetn && awvalid && awready) begin
            assert (awaddr == exp_waddr) else report_mismatch("awaddr", exp_waddr, awaddr);
            assert (awid == `ID_DCACHE) else report_mismatch("awid", `ID_DCACHE, awid);
            aw_addr = awaddr;
            aw_seen = 1'b1;
        end
        if (aresetn && wvalid && wready) begin
            assert (w_q.size() < `BURST_BEATS) else begin
                errors++;
                $display("more than 16 W beats in one write burst");
            end
            assert (wlast == (w_q.size() == `BURST_BEATS - 1))
            else report_mismatch("wlast", w_q.size() == `BURST_BEATS - 1, wlast);
            assert (wstrb == exp_wstrb) else report_mismatch("wstrb", exp_wstrb, wstrb);
            wstrb_q = wstrb;
            w_q.push_back(wdata);
        end
        if (b_hs) begin
            b_count++;
            aw_seen = 1'b0;
            w_q.delete();
        end
        #2;
        if (b_hs) begin
            bvalid = 1'b0;
        end else if (aw_seen && w_q.size() == `BURST_BEATS && !bvalid) begin
            for (int k = 0; k < `BURST_BEATS; k++) begin
                mem[aw_addr[11:2] + k] = merge_bytes(mem[aw_addr[11:2] + k], w_q[k], wstrb_q);
            end
            bvalid = 1'b1;
        end
    end

    // R side, newest accepted burst goes first
    initial begin
        addr_t   ra;
        axi_id_t rd;
        rvalid = 1'b0;
        rlast = 1'b0;
        rid = '0;
        rdata = '0;
        forever begin
            @(posedge aclk);
            if (rd_addr_q.size() > 0) begin
                repeat (8) @(posedge aclk);
                ra = rd_addr_q.pop_back();
                rd = rd_id_q.pop_back();
                for (int k = 0; k < `BURST_BEATS; k++) begin
                    #2;
                    rvalid = 1'b1;
                    rid = rd;
                    rdata = mem[ra[11:2] + k];
                    rlast = (k == `BURST_BEATS - 1);
                    @(posedge aclk);
                    while (!rready) @(posedge aclk);
                end
                #2;
                rvalid = 1'b0;
                rlast = 1'b0;
            end
        end
    end

    // cache-side beat checks
    always @(posedge aclk) begin
        if (ic_ret_valid) begin
            assert (ic_rdata == ref_mem[ic_base[11:2] + ic_idx])
            else report_mismatch("ic_rdata", ref_mem[ic_base[11:2] + ic_idx], ic_rdata);
            assert (ic_ret_last == (ic_idx == 15))
            else report_mismatch("ic_ret_last", ic_idx == 15, ic_ret_last);
            ic_idx = (ic_idx + 1) % `BURST_BEATS;
            if (ic_idx == 0) ic_lines++;
        end
        if (dc_ret_valid) begin
            assert (dc_rdata == ref_mem[dc_base[11:2] + dc_idx])
            else report_mismatch("dc_rdata", ref_mem[dc_base[11:2] + dc_idx], dc_rdata);
            assert (dc_ret_last == (dc_idx == 15))
            else report_mismatch("dc_ret_last", dc_idx == 15, dc_ret_last);
            dc_idx = (dc_idx + 1) % `BURST_BEATS;
            if (dc_idx == 0) dc_lines++;
        end
        if (dc_b_valid) dc_b_cnt++;
    end

    task automatic read_line(input rd_src_t src, input addr_t a);
        int start;
        if (src == ICACHE) begin
            start = ic_lines;
            ic_base = a;
            ic_addr = a;
            ic_req = 1'b1;
            @(posedge aclk);
            while (!ic_rdy) @(posedge aclk);
            #2;
            ic_req = 1'b0;
            while (ic_lines == start) @(posedge aclk);
        end else begin
            start = dc_lines;
            dc_base = a;
            dc_addr = a;
            dc_req = 1'b1;
            @(posedge aclk);
            while (!dc_rdy) @(posedge aclk);
            #2;
            dc_req = 1'b0;
            while (dc_lines == start) @(posedge aclk);
        end
        #2;
    endtask

    // second line requested while the first is still returning
    task automatic read_ic_overlapped(input addr_t a0, input addr_t a1);
        int start;
        start = ic_lines;
        ic_base = a0;
        ic_addr = a0;
        ic_req = 1'b1;
        @(posedge aclk);
        while (!ic_rdy) @(posedge aclk);
        #2;
        ic_req = 1'b0;
        @(posedge aclk);
        #2;
        ic_addr = a1;
        ic_req = 1'b1;
        while (ic_lines == start) @(posedge aclk);
        ic_base = a1;
        while (!ic_rdy) @(posedge aclk);
        #2;
        ic_req = 1'b0;
        while (ic_lines == start + 1) @(posedge aclk);
        #2;
    endtask

    task automatic write_line(input addr_t a, input strb_t s);
        int    start;
        word_t wd;
        start = dc_b_cnt;
        exp_waddr = a;
        exp_wstrb = s;
        dc_w_addr = a;
        dc_w_strb = s;
        dc_w_req = 1'b1;
        @(posedge aclk);
        while (!dc_w_rdy) @(posedge aclk);
        #2;
        dc_w_req = 1'b0;
        for (int k = 0; k < `BURST_BEATS; k++) begin
            wd = $random(seed);
            ref_mem[a[11:2] + k] = merge_bytes(ref_mem[a[11:2] + k], wd, s);
            dc_w_data = wd;
            dc_w_data_req = 1'b1;
            @(posedge aclk);
            while (!dc_w_data_ready) @(posedge aclk);
            #2;
        end
        dc_w_data_req = 1'b0;
        while (dc_b_cnt == start) @(posedge aclk);
        #2;
    endtask

    initial begin
        axi_id_t exp_id;
        int      n;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        {ic_req, dc_req, dc_w_req, dc_w_data_req} = '0;
        {ic_addr, dc_addr, dc_w_addr, dc_w_data} = '0;
        dc_w_strb = '0;
        {arready, awready, wready, bvalid, ic_data_ready, dc_data_ready} = '0;
        {aw_seen, outstanding} = '0;
        aresetn = 1'b0;
        repeat (3) @(posedge aclk);
        #2;
        aresetn = 1'b1;
        assert (!arvalid && !awvalid && !wvalid && !bready && !ic_rdy && !dc_rdy &&
                !dc_b_valid && !dc_w_rdy) else begin
            errors++;
            $display("outputs not idle after reset");
        end
        read_ic_overlapped(32'h100, 32'h0c0);
        // both sides in the same cycle, twice
        for (int t = 0; t < 2; t++) begin
            exp_id = (ar_ids[$] == `ID_ICACHE) ? `ID_DCACHE : `ID_ICACHE;
            n = ar_ids.size();
            fork
                read_line(ICACHE, 32'h140 + t * 64);
                read_line(DCACHE, 32'h380 - t * 64);
            join
            assert (ar_ids[n] == exp_id) else report_mismatch("arid", exp_id, ar_ids[n]);
        end
        write_line(32'h200, 4'hf);
        read_line(DCACHE, 32'h200);
        // partial strobes keep the odd byte lanes
        write_line(32'h3c0, 4'h5);
        read_line(DCACHE, 32'h3c0);
        read_line(ICACHE, 32'h200);
        assert (dc_b_cnt == 2) else report_mismatch("dc_b_valid count", 2, dc_b_cnt);
        assert (b_count == 2) else report_mismatch("B handshake count", 2, b_count);
        $display("errors: data %0d, assertions %0d", errors, DUT.u_asserts.fail_cnt);
        if (errors == 0 && DUT.u_asserts.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- refill_bridge_top.sv
`timescale 1ns/1ns

module refill_bridge_top (
    input  logic                       aclk,
    input  logic                       aresetn,
    // instruction cache side
    input  logic                       i_ic_req,
    input  refill_bridge_pkg::addr_t   i_ic_addr,
    output logic                       o_ic_rdy,
    output logic                       o_ic_ret_valid,
    output logic                       o_ic_ret_last,
    output refill_bridge_pkg::word_t   o_ic_rdata,
    input  logic                       i_ic_data_ready,
    // data cache side, reads
    input  logic                       i_dc_req,
    input  refill_bridge_pkg::addr_t   i_dc_addr,
    output logic                       o_dc_rdy,
    output logic                       o_dc_ret_valid,
    output logic                       o_dc_ret_last,
    output refill_bridge_pkg::word_t   o_dc_rdata,
    input  logic                       i_dc_data_ready,
    // data cache side, write-back
    input  logic                       i_dc_w_req,
    input  refill_bridge_pkg::addr_t   i_dc_w_addr,
    input  refill_bridge_pkg::strb_t   i_dc_w_strb,
    output logic                       o_dc_w_rdy,
    input  logic                       i_dc_w_data_req,
    input  refill_bridge_pkg::word_t   i_dc_w_data,
    output logic                       o_dc_w_data_ready,
    output logic                       o_dc_b_valid,
    // AXI read address
    output refill_bridge_pkg::axi_id_t o_arid,
    output refill_bridge_pkg::addr_t   o_araddr,
    output logic                       o_arvalid,
    input  logic                       i_arready,
    // AXI read data
    input  refill_bridge_pkg::axi_id_t i_rid,
    input  refill_bridge_pkg::word_t   i_rdata,
    input  logic                       i_rlast,
    input  logic                       i_rvalid,
    output logic                       o_rready,
    // AXI write address
    output refill_bridge_pkg::axi_id_t o_awid,
    output refill_bridge_pkg::addr_t   o_awaddr,
    output logic                       o_awvalid,
    input  logic                       i_awready,
    // AXI write data
    output refill_bridge_pkg::word_t   o_wdata,
    output refill_bridge_pkg::strb_t   o_wstrb,
    output logic                       o_wlast,
    output logic                       o_wvalid,
    input  logic                       i_wready,
    // AXI write response
    input  logic                       i_bvalid,
    output logic                       o_bready
);
    import refill_bridge_pkg::*;

    logic    ar_load;
    rd_src_t ar_src;
    logic    ar_busy;
    logic    ar_done;
    logic    rlast_beat;
    rd_src_t rlast_src;
    logic    aw_load;
    logic    w_active;
    logic    b_wait;
    logic    w_last_done;
    logic    b_done;

    refill_ctrl u_ctrl (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_ic_req      (i_ic_req),
        .i_dc_req      (i_dc_req),
        .i_dc_w_req    (i_dc_w_req),
        .i_ar_busy     (ar_busy),
        .i_ar_done     (ar_done),
        .i_rlast_beat  (rlast_beat),
        .i_rlast_src   (rlast_src),
        .i_w_last_done (w_last_done),
        .i_b_done      (b_done),
        .o_ar_load     (ar_load),
        .o_ar_src      (ar_src),
        .o_aw_load     (aw_load),
        .o_w_active    (w_active),
        .o_b_wait      (b_wait)
    );

    ar_channel u_ar (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_load    (ar_load),
        .i_src     (ar_src),
        .i_ic_addr (i_ic_addr),
        .i_dc_addr (i_dc_addr),
        .i_arready (i_arready),
        .o_arvalid (o_arvalid),
        .o_araddr  (o_araddr),
        .o_arid    (o_arid),
        .o_busy    (ar_busy),
        .o_done    (ar_done),
        .o_ic_rdy  (o_ic_rdy),
        .o_dc_rdy  (o_dc_rdy)
    );

    r_router u_r (
        .i_rvalid        (i_rvalid),
        .i_rid           (i_rid),
        .i_rdata         (i_rdata),
        .i_rlast         (i_rlast),
        .i_ic_data_ready (i_ic_data_ready),
        .i_dc_data_ready (i_dc_data_ready),
        .o_rready        (o_rready),
        .o_ic_ret_valid  (o_ic_ret_valid),
        .o_ic_ret_last   (o_ic_ret_last),
        .o_ic_rdata      (o_ic_rdata),
        .o_dc_ret_valid  (o_dc_ret_valid),
        .o_dc_ret_last   (o_dc_ret_last),
        .o_dc_rdata      (o_dc_rdata),
        .o_rlast_beat    (rlast_beat),
        .o_rlast_src     (rlast_src)
    );

    w_channel u_w (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_load         (aw_load),
        .i_active       (w_active),
        .i_b_wait       (b_wait),
        .i_w_addr       (i_dc_w_addr),
        .i_w_strb       (i_dc_w_strb),
        .i_w_data_req   (i_dc_w_data_req),
        .i_w_data       (i_dc_w_data),
        .i_awready      (i_awready),
        .i_wready       (i_wready),
        .i_bvalid       (i_bvalid),
        .o_awvalid      (o_awvalid),
        .o_awaddr       (o_awaddr),
        .o_awid         (o_awid),
        .o_wvalid       (o_wvalid),
        .o_wdata        (o_wdata),
        .o_wstrb        (o_wstrb),
        .o_wlast        (o_wlast),
        .o_bready       (o_bready),
        .o_w_rdy        (o_dc_w_rdy),
        .o_w_data_ready (o_dc_w_data_ready),
        .o_last_done    (w_last_done),
        .o_b_done       (b_done),
        .o_b_valid      (o_dc_b_valid)
    );

endmodule

//--- refill_ctrl.sv
`timescale 1ns/1ns

module refill_ctrl (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       i_ic_req,
    input  logic                       i_dc_req,
    input  logic                       i_dc_w_req,
    input  logic                       i_ar_busy,
    input  logic                       i_ar_done,
    input  logic                       i_rlast_beat,
    input  refill_bridge_pkg::rd_src_t i_rlast_src,
    input  logic                       i_w_last_done,
    input  logic                       i_b_done,
    output logic                       o_ar_load,
    output refill_bridge_pkg::rd_src_t o_ar_src,
    output logic                       o_aw_load,
    output logic                       o_w_active,
    output logic                       o_b_wait
);
    import refill_bridge_pkg::*;

    logic [1:0] rd_busy;
    rd_src_t    last_grant;
    logic       ic_pend;
    logic       dc_pend;
    logic       ar_free;
    wr_state_t  wr_state;
    wr_state_t  wr_next;

    // a source with a burst in flight waits for its rlast
    assign ic_pend = i_ic_req && !rd_busy[ICACHE];
    assign dc_pend = i_dc_req && !rd_busy[DCACHE];

    // address register may reload in its own handshake cycle
    assign ar_free   = !i_ar_busy || i_ar_done;
    assign o_ar_load = ar_free && (ic_pend || dc_pend);

    always_comb begin
        if (ic_pend && dc_pend) begin
            // tie goes to the side not granted last
            if (last_grant == ICACHE) begin
                o_ar_src = DCACHE;
            end else begin
                o_ar_src = ICACHE;
            end
        end else if (dc_pend) begin
            o_ar_src = DCACHE;
        end else begin
            o_ar_src = ICACHE;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_busy    <= '0;
            last_grant <= DCACHE;
        end else begin
            if (o_ar_load) begin
                rd_busy[o_ar_src] <= 1'b1;
                last_grant        <= o_ar_src;
            end
            if (i_rlast_beat) begin
                rd_busy[i_rlast_src] <= 1'b0;
            end
        end
    end

    // write-back sequencing
    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            W_IDLE: begin
                if (i_dc_w_req) begin
                    wr_next = W_ADDR;
                end
            end
            // first cycle of awvalid, data follows the AW pulse
            W_ADDR: begin
                wr_next = W_DATA;
            end
            W_DATA: begin
                if (i_w_last_done) begin
                    wr_next = W_RESP;
                end
            end
            W_RESP: begin
                if (i_b_done) begin
                    wr_next = W_IDLE;
                end
            end
            default: begin
                wr_next = W_IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_state <= W_IDLE;
        end else begin
            wr_state <= wr_next;
        end
    end

    assign o_aw_load  = (wr_state == W_IDLE) && i_dc_w_req;
    assign o_w_active = (wr_state == W_DATA);
    assign o_b_wait   = (wr_state == W_RESP);

endmodule

//--- sim.f
+incdir+.
refill_bridge_pkg.sv
refill_ctrl.sv
ar_channel.sv
r_router.sv
w_channel.sv
refill_bridge_top.sv
refill_bridge_asserts.sv
refill_bridge_tb.sv

//--- w_channel.sv
`timescale 1ns/1ns
`include "refill_bridge_defs.svh"

module w_channel (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       i_load,
    input  logic                       i_active,
    input  logic                       i_b_wait,
    input  refill_bridge_pkg::addr_t   i_w_addr,
    input  refill_bridge_pkg::strb_t   i_w_strb,
    input  logic                       i_w_data_req,
    input  refill_bridge_pkg::word_t   i_w_data,
    input  logic                       i_awready,
    input  logic                       i_wready,
    input  logic                       i_bvalid,
    output logic                       o_awvalid,
    output refill_bridge_pkg::addr_t   o_awaddr,
    output refill_bridge_pkg::axi_id_t o_awid,
    output logic                       o_wvalid,
    output refill_bridge_pkg::word_t   o_wdata,
    output refill_bridge_pkg::strb_t   o_wstrb,
    output logic                       o_wlast,
    output logic                       o_bready,
    output logic                       o_w_rdy,
    output logic                       o_w_data_ready,
    output logic                       o_last_done,
    output logic                       o_b_done,
    output logic                       o_b_valid
);
    import refill_bridge_pkg::*;

    logic      awvalid_q;
    beat_cnt_t beat_cnt;
    logic      beat_take;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            awvalid_q <= 1'b0;
        end else if (i_load) begin
            awvalid_q <= 1'b1;
        end else if (o_w_rdy) begin
            awvalid_q <= 1'b0;
        end
    end

    // strobes hold for the whole line
    always_ff @(posedge aclk) begin
        if (i_load) begin
            o_awaddr <= i_w_addr;
            o_wstrb  <= i_w_strb;
        end
    end

    assign o_awvalid = awvalid_q;
    assign o_awid    = axi_id_t'(`ID_DCACHE);
    assign o_w_rdy   = awvalid_q && i_awready;

    // write words pass straight through while the data phase is open
    assign o_wvalid       = i_active && i_w_data_req;
    assign o_wdata        = i_w_data;
    assign beat_take      = o_wvalid && i_wready;
    assign o_w_data_ready = beat_take;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            beat_cnt <= '0;
        end else if (i_load) begin
            beat_cnt <= '0;
        end else if (beat_take) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign o_wlast     = (beat_cnt == beat_cnt_t'(`BURST_BEATS - 1));
    assign o_last_done = beat_take && o_wlast;

    // response side
    assign o_bready  = i_b_wait;
    assign o_b_done  = i_b_wait && i_bvalid;
    assign o_b_valid = o_b_done;

endmodule
